// File: lp_cfg.svh
//********************
// loop platform configuration
// stream widths, fifo depth and register script pacing
//********************
`ifndef LP_CFG_SVH
`define LP_CFG_SVH

//********************
// stream path
//********************
`define LP_WORD_W      32   // host side word
`define LP_BEAT_W      64   // internal beat, two host words
`define LP_FIFO_DEPTH  16   // beats, keep it a power of two

//********************
// register script
//********************
`define LP_GAP_CYCLES  10   // clocks from one write to the next
`define LP_SCRIPT_LEN  20   // five lli nodes of four words
`define LP_ADDR_W      32   // register bus address

`endif

// File: lp_pkg.sv
//********************
// loop platform types
// stream word, internal beat and register write entry
//********************
`include "lp_cfg.svh"

package lp_pkg;

    // one word on the host stream
    typedef struct packed {
        logic [`LP_WORD_W-1:0]   data;
        logic [`LP_WORD_W/8-1:0] keep;   // byte enables, low bytes first
        logic                    last;   // closes the packet
    } host_word_t;

    // one beat between packer, fifo and unpacker
    typedef struct packed {
        logic [`LP_BEAT_W-1:0]   data;   // high half is the later word
        logic [`LP_BEAT_W/8-1:0] keep;   // upper nibble zero on a half beat
        logic                    last;
    } stream_beat_t;

    // one script entry, also the bus write itself
    typedef struct packed {
        logic [`LP_ADDR_W-1:0] addr;
        logic [`LP_WORD_W-1:0] data;
    } reg_write_t;

    // index into the script table
    typedef logic [$clog2(`LP_SCRIPT_LEN)-1:0] script_idx_t;

endpackage

// File: word_packer.sv
//********************
// word packer
// joins two host words into one beat, low word first
// a last word closes the beat early with upper keep zero
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module word_packer
(
    input  logic                 clk_80m,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  lp_pkg::host_word_t   in_word,
    output logic                 in_ready,
    output logic                 pk_valid,
    output lp_pkg::stream_beat_t pk_beat,
    input  logic                 pk_ready
);
    import lp_pkg::*;

    localparam int KEEP_W = `LP_WORD_W / 8;

    host_word_t lo_word;    // first word of the beat being built
    logic       lo_full;    // lo_word holds a word
    logic       run_q;      // up one cycle after reset
    logic       in_fire;
    logic       close_beat; // this word completes a beat

    // stall input while a finished beat waits downstream
    assign in_ready   = run_q && (!pk_valid || pk_ready);
    assign in_fire    = in_valid && in_ready;
    assign close_beat = in_fire && (lo_full || in_word.last);

    //********************
    // control
    //********************
    always_ff @(posedge clk_80m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            run_q    <= 1'b0;
            lo_full  <= 1'b0;
            pk_valid <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            if (close_beat)
            begin
                lo_full  <= 1'b0;
                pk_valid <= 1'b1;   // new beat replaces any beat taken this cycle
            end
            else
            begin
                if (in_fire)
                    lo_full <= 1'b1;    // first half parked
                if (pk_ready)
                    pk_valid <= 1'b0;
            end
        end
    end

    //********************
    // datapath
    //********************
    always_ff @(posedge clk_80m)
    begin
        if (in_fire && !lo_full)
            lo_word <= in_word;
        if (in_fire && lo_full)
        begin
            pk_beat.data <= {in_word.data, lo_word.data};
            pk_beat.keep <= {in_word.keep, lo_word.keep};
            pk_beat.last <= in_word.last;
        end
        else if (in_fire && in_word.last)
        begin
            // single word packet tail, upper half empty
            pk_beat.data <= {{`LP_WORD_W{1'b0}}, in_word.data};
            pk_beat.keep <= {{KEEP_W{1'b0}}, in_word.keep};
            pk_beat.last <= 1'b1;
        end
    end

endmodule

// File: stream_fifo.sv
//********************
// stream fifo
// circular buffer of beats, valid/ready on both sides
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module stream_fifo
#(
    parameter int DEPTH = `LP_FIFO_DEPTH    // power of two, 2 or more
)
(
    input  logic                 clk_80m,
    input  logic                 rst_n,
    input  logic                 wr_valid,
    input  lp_pkg::stream_beat_t wr_beat,
    output logic                 wr_ready,
    output logic                 rd_valid,
    output lp_pkg::stream_beat_t rd_beat,
    input  logic                 rd_ready
);
    import lp_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    stream_beat_t     mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;   // wraps on its own
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;    // beats held
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (count != CNT_W'(DEPTH));    // full
    assign rd_valid = (count != '0);               // empty
    assign rd_beat  = mem[rd_ptr];                 // head always on the output
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    //********************
    // storage
    //********************
    always_ff @(posedge clk_80m)
    begin
        if (wr_fire)
            mem[wr_ptr] <= wr_beat;
    end

    //********************
    // pointers and count
    //********************
    always_ff @(posedge clk_80m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_fire)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither, no change
            endcase
        end
    end

endmodule

// File: word_unpacker.sv
//********************
// word unpacker
// splits beats into host words, low half first
// upper half skipped when its keep is zero
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module word_unpacker
(
    input  logic                 clk_80m,
    input  logic                 rst_n,
    input  logic                 fo_valid,
    input  lp_pkg::stream_beat_t fo_beat,
    output logic                 fo_ready,
    output logic                 out_valid,
    output lp_pkg::host_word_t   out_word,
    input  logic                 out_ready
);
    import lp_pkg::*;

    localparam int KEEP_W = `LP_WORD_W / 8;

    host_word_t        hi_word;     // upper half waiting its turn
    logic              hi_pending;
    logic              adv;         // output register free this cycle
    logic              fo_fire;
    logic [KEEP_W-1:0] hi_keep;

    assign hi_keep  = fo_beat.keep[`LP_BEAT_W/8-1:KEEP_W];
    assign adv      = !out_valid || out_ready;
    assign fo_ready = !hi_pending && adv;   // next beat only once this one is out
    assign fo_fire  = fo_valid && fo_ready;

    //********************
    // control
    //********************
    always_ff @(posedge clk_80m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid  <= 1'b0;
            hi_pending <= 1'b0;
        end
        else if (hi_pending && adv)
        begin
            out_valid  <= 1'b1;  // second word goes out
            hi_pending <= 1'b0;
        end
        else if (fo_fire)
        begin
            out_valid  <= 1'b1;
            hi_pending <= (hi_keep != '0);
        end
        else if (adv)
        begin
            out_valid <= 1'b0;   // drained
        end
    end

    //********************
    // datapath
    //********************
    always_ff @(posedge clk_80m)
    begin
        if (hi_pending && adv)
        begin
            out_word <= hi_word;
        end
        else if (fo_fire)
        begin
            out_word.data <= fo_beat.data[`LP_WORD_W-1:0];
            out_word.keep <= fo_beat.keep[KEEP_W-1:0];
            out_word.last <= fo_beat.last && (hi_keep == '0); // last only if no upper word
            hi_word.data  <= fo_beat.data[`LP_BEAT_W-1:`LP_WORD_W];
            hi_word.keep  <= hi_keep;
            hi_word.last  <= fo_beat.last;
        end
    end

endmodule

// File: reg_script_rom.sv
//********************
// register script table
// five lli descriptor nodes, four words each
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module reg_script_rom
(
    input  lp_pkg::script_idx_t idx,
    output lp_pkg::reg_write_t  entry
);
    import lp_pkg::*;

    localparam logic [`LP_ADDR_W-1:0] LLI_BASE  = 32'h6000_0000;  // node 0 in sram
    localparam logic [`LP_WORD_W-1:0] SRC_BASE  = 32'h2000_0100;
    localparam logic [`LP_WORD_W-1:0] DST_BASE  = 32'h6000_0100;
    localparam logic [2:0]            LAST_NODE = 3'(`LP_SCRIPT_LEN / 4 - 1);

    logic [2:0]            node;        // entry / 4
    logic [1:0]            word;        // word inside the node
    logic [`LP_ADDR_W-1:0] node_base;
    logic [`LP_WORD_W-1:0] node_len;

    assign node      = 3'(idx >> 2);
    assign word      = idx[1:0];
    assign node_base = LLI_BASE + `LP_ADDR_W'({node, 5'b0});    // 0x20 per node

    // transfer length per node
    always_comb
    begin
        case (node)
            3'd0, 3'd1: node_len = 32'h08;
            3'd2, 3'd3: node_len = 32'h10;
            3'd4:       node_len = 32'h18;
            default:    node_len = '0;
        endcase
    end

    always_comb
    begin
        entry.addr = node_base + `LP_ADDR_W'({word, 2'b0});
        case (word)
            2'd0:    entry.data = SRC_BASE + `LP_WORD_W'({node, 8'h00});  // source
            2'd1:    entry.data = DST_BASE + `LP_WORD_W'({node, 8'h00});  // destination
            2'd2:    entry.data = node_len;
            default: entry.data = (node == LAST_NODE) ? '0 : node_base + 32'h20; // next
        endcase
        // past the table end
        if (idx >= script_idx_t'(`LP_SCRIPT_LEN))
            entry = '0;
    end

endmodule

// File: gap_timer.sv
//********************
// gap timer
// down counter, expire pulses LP_GAP_CYCLES clocks after load
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module gap_timer
(
    input  logic clk_80m,
    input  logic rst_n,
    input  logic load,
    output logic expire
);

    localparam int CNT_W = $clog2(`LP_GAP_CYCLES + 1);

    logic [CNT_W-1:0] cnt;  // zero means idle

    // one cycle pulse on the final count
    assign expire = (cnt == CNT_W'(1));

    always_ff @(posedge clk_80m or negedge rst_n)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (load)
            cnt <= CNT_W'(`LP_GAP_CYCLES);  // reload wins over counting
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

endmodule

// File: reg_script_fsm.sv
//********************
// register script FSM
// steps through the table on start, one write per timer gap
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module reg_script_fsm
(
    input  logic                clk_80m,
    input  logic                rst_n,
    input  logic                start,
    input  logic                expire,
    output logic                load,
    output lp_pkg::script_idx_t idx,
    input  lp_pkg::reg_write_t  entry,
    output logic                reg_wr,
    output lp_pkg::reg_write_t  reg_bus,
    output logic                busy,
    output logic                done
);
    import lp_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,     // timer running
        S_WRITE     // strobe cycle
    } state_t;

    localparam script_idx_t LAST_IDX = script_idx_t'(`LP_SCRIPT_LEN - 1);

    state_t state;
    logic   go;
    logic   last_entry;

    assign go         = (state == S_IDLE) && start && !done;   // ignored while busy
    assign last_entry = (idx == LAST_IDX);

    // reload on expire keeps the spacing exact
    assign load   = go || ((state == S_WAIT) && expire && !last_entry);
    assign reg_wr = (state == S_WRITE);
    assign busy   = (state != S_IDLE) || done;   // done cycle still counts

    //********************
    // state and index
    //********************
    always_ff @(posedge clk_80m or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= S_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (go)
                    begin
                        state <= S_WAIT;
                        idx   <= '0;
                    end
                end
                S_WAIT:
                begin
                    if (expire)
                        state <= S_WRITE;
                end
                S_WRITE:
                begin
                    if (last_entry)
                    begin
                        state <= S_IDLE;
                        idx   <= '0;
                        done  <= 1'b1;   // one cycle after the last strobe
                    end
                    else
                    begin
                        state <= S_WAIT;
                        idx   <= idx + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // capture table entry for the strobe cycle
    always_ff @(posedge clk_80m)
    begin
        if ((state == S_WAIT) && expire)
            reg_bus <= entry;
    end

endmodule

// File: loop_platform_top.sv
//********************
// loop platform top
// host stream loopback through one fifo, plus register script writer
//********************
`timescale 1ns/100ps

module loop_platform_top
(
    input  logic               clk_80m,
    input  logic               rst_n,
    input  logic               in_valid,
    input  lp_pkg::host_word_t in_word,
    output logic               in_ready,
    output logic               out_valid,
    output lp_pkg::host_word_t out_word,
    input  logic               out_ready,
    input  logic               start,
    output logic               reg_wr,
    output lp_pkg::reg_write_t reg_bus,
    output logic               busy,
    output logic               done
);
    import lp_pkg::*;

    stream_beat_t pk_beat;  // packer to fifo
    logic         pk_valid;
    logic         pk_ready;
    stream_beat_t fo_beat;  // fifo to unpacker
    logic         fo_valid;
    logic         fo_ready;
    logic         tm_load;
    logic         tm_expire;
    script_idx_t  rom_idx;
    reg_write_t   rom_entry;

    //********************
    // loopback stream path
    //********************
    word_packer u_packer (
        .clk_80m  (clk_80m),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_word  (in_word),
        .in_ready (in_ready),
        .pk_valid (pk_valid),
        .pk_beat  (pk_beat),
        .pk_ready (pk_ready)
    );

    stream_fifo u_fifo (
        .clk_80m  (clk_80m),
        .rst_n    (rst_n),
        .wr_valid (pk_valid),
        .wr_beat  (pk_beat),
        .wr_ready (pk_ready),
        .rd_valid (fo_valid),
        .rd_beat  (fo_beat),
        .rd_ready (fo_ready)
    );

    word_unpacker u_unpacker (
        .clk_80m   (clk_80m),
        .rst_n     (rst_n),
        .fo_valid  (fo_valid),
        .fo_beat   (fo_beat),
        .fo_ready  (fo_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready)
    );

    //********************
    // register script writer
    //********************
    reg_script_fsm u_fsm (
        .clk_80m (clk_80m),
        .rst_n   (rst_n),
        .start   (start),
        .expire  (tm_expire),
        .load    (tm_load),
        .idx     (rom_idx),
        .entry   (rom_entry),
        .reg_wr  (reg_wr),
        .reg_bus (reg_bus),
        .busy    (busy),
        .done    (done)
    );

    gap_timer u_timer (
        .clk_80m (clk_80m),
        .rst_n   (rst_n),
        .load    (tm_load),
        .expire  (tm_expire)
    );

    reg_script_rom u_rom (
        .idx   (rom_idx),
        .entry (rom_entry)
    );

endmodule

// File: tb_loop_platform.sv
//********************
// loop platform testbench
// stream loopback with stalls, register script timing and content
//********************
`timescale 1ns/100ps
`include "lp_cfg.svh"

module tb_loop_platform;
    import lp_pkg::*;

    localparam int WAIT_LIMIT = 400;    // cycles per wait loop

    logic       clk_80m;
    logic       rst_n;
    logic       in_valid;
    host_word_t in_word;
    logic       in_ready;
    logic       out_valid;
    host_word_t out_word;
    logic       out_ready;
    logic       start;
    logic       reg_wr;
    reg_write_t reg_bus;
    logic       busy;
    logic       done;

    host_word_t exp_q[$];       // words still owed by the loopback
    host_word_t want;
    reg_write_t exp_wr;
    int         errors = 0;
    int         cyc = 0;        // posedge count
    int         start_edge;
    int         last_rise;
    int         wr_count;
    int         runs_done = 0;
    int         stall_mode = 0; // 0 ready, 1 random, 2 held low
    logic       checking = 1'b0;
    logic       script_run = 1'b0;
    logic       saw_full;
    logic       timed_out = 1'b0;
    logic       exp_busy;

    loop_platform_top dut (
        .clk_80m   (clk_80m),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_word  (out_word),
        .out_ready (out_ready),
        .start     (start),
        .reg_wr    (reg_wr),
        .reg_bus   (reg_bus),
        .busy      (busy),
        .done      (done)
    );

    initial
    begin
        clk_80m = 1'b0;
        forever #4 clk_80m = ~clk_80m;  // 8 ns period
    end

    //********************
    // reference models
    //********************
    // loopback returns every word as sent
    function automatic host_word_t loopback_ref(input host_word_t w);
        return w;
    endfunction

    // lli node n at 0x6000_0000 + 0x20*n, word k at +4*k
    function automatic reg_write_t script_ref(input int i);
        int         n;
        int         k;
        reg_write_t e;
        n = i / 4;
        k = i % 4;
        e.addr = 32'h6000_0000 + 32'h20 * n + 4 * k;
        case (k)
            0:       e.data = 32'h2000_0100 + 32'h100 * n;     // source
            1:       e.data = 32'h6000_0100 + 32'h100 * n;     // destination
            2:       e.data = (n < 2) ? 32'h08 : (n < 4) ? 32'h10 : 32'h18;
            default: e.data = (n == 4) ? 32'h0 : 32'h6000_0000 + 32'h20 * (n + 1);
        endcase
        return e;
    endfunction

    task automatic check_val(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("mismatch at %0t: %s expected %0h actual %0h", $time, what,
                     expected, actual);
        end
    endtask

    //********************
    // stimulus helpers
    //********************
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk_80m);
            #1;
        end
    endtask

    // entered 1 ns after an edge, leaves 1 ns after the accepting edge
    task automatic push_word(input host_word_t w);
        int waited;
        waited = 0;
        if (!timed_out)
        begin
            in_valid = 1'b1;
            in_word  = w;
            @(posedge clk_80m);
            while (!in_ready && !timed_out)
            begin
                waited++;
                if (waited > WAIT_LIMIT)
                begin
                    errors++;
                    timed_out = 1'b1;
                    $display("timeout at %0t: input word was never accepted", $time);
                end
                else
                    @(posedge clk_80m);
            end
            if (!timed_out)
                exp_q.push_back(loopback_ref(w));
            #1;
        end
    endtask

    task automatic send_packet(input int len, input logic [3:0] tail_keep);
        host_word_t w;
        for (int i = 0; i < len; i++)
        begin
            w.data = $urandom;
            w.last = (i == len - 1);
            w.keep = w.last ? tail_keep : 4'hf;   // low bytes only
            push_word(w);
        end
        in_valid = 1'b0;
        idle_cycles($urandom % 3);
    endtask

    function automatic logic [3:0] pick_keep();
        case ($urandom % 4)
            0:       return 4'h1;
            1:       return 4'h3;
            2:       return 4'h7;
            default: return 4'hf;
        endcase
    endfunction

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk_80m);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_runs(input int n);
        int waited;
        waited = 0;
        while (runs_done < n && waited <= WAIT_LIMIT)
        begin
            idle_cycles(1);
            waited++;
        end
        if (runs_done < n)
        begin
            errors++;
            $display("timeout at %0t: script run %0d never finished", $time, n);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited <= WAIT_LIMIT)
        begin
            idle_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("timeout at %0t: %0d words never left the loopback", $time,
                     exp_q.size());
        end
    endtask

    // out_ready pattern set 1 ns after each edge
    initial
    begin
        forever
        begin
            @(posedge clk_80m);
            #1;
            case (stall_mode)
                0:       out_ready = 1'b1;
                1:       out_ready = ($urandom % 4) != 0;
                default: out_ready = 1'b0;
            endcase
        end
    end

    //********************
    // compare process
    //********************
    always @(posedge clk_80m)
    begin
        cyc = cyc + 1;
        if (checking)
        begin
            if (in_valid && !in_ready)
                saw_full = 1'b1;    // only a full path stalls the input
            if (out_valid && out_ready)
            begin
                if (exp_q.size() == 0)
                begin
                    errors++;
                    $display("extra output word %h at %0t with nothing pending", out_word,
                             $time);
                end
                else
                begin
                    want = exp_q.pop_front();
                    check_val("out_word.data", want.data, out_word.data);
                    check_val("out_word.keep", want.keep, out_word.keep);
                    check_val("out_word.last", want.last, out_word.last);
                end
            end
            exp_busy = script_run && (cyc > start_edge);
            check_val("busy", exp_busy, busy);
            if (start && !script_run)
            begin
                script_run = 1'b1;      // busy or done cycle would ignore it
                start_edge = cyc;
                wr_count   = 0;
            end
            if (reg_wr)
            begin
                if (!script_run || wr_count >= `LP_SCRIPT_LEN)
                begin
                    errors++;
                    $display("write strobe at %0t outside a script run", $time);
                end
                else
                begin
                    // strobe rose on the previous edge
                    check_val("reg_wr edge", (wr_count == 0) ? start_edge + `LP_GAP_CYCLES
                              : last_rise + `LP_GAP_CYCLES, cyc - 1);
                    exp_wr = script_ref(wr_count);
                    check_val("reg_bus.addr", exp_wr.addr, reg_bus.addr);
                    check_val("reg_bus.data", exp_wr.data, reg_bus.data);
                    last_rise = cyc - 1;
                    wr_count++;
                end
            end
            if (done)
            begin
                if (!script_run)
                begin
                    errors++;
                    $display("done pulse at %0t outside a script run", $time);
                end
                else
                begin
                    check_val("write count", `LP_SCRIPT_LEN, wr_count);
                    check_val("done edge", last_rise + 1, cyc - 1);
                    runs_done++;
                    script_run = 1'b0;
                end
            end
        end
    end

    //********************
    // main sequence
    //********************
    initial
    begin
        void'($urandom(32'hd46c_ed84));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;
        start     = 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            @(posedge clk_80m);
            if (i > 0)    // flops settle on the first edge
                check_val("reset outputs", 5'b0, {in_ready, out_valid, reg_wr, busy, done});
        end
        #1;
        rst_n = 1'b1;
        @(posedge clk_80m);
        check_val("outputs after reset", 5'b0,
                  {in_ready, out_valid, reg_wr, busy, done});
        @(posedge clk_80m);
        check_val("in_ready", 1'b1, in_ready);
        #1;
        checking = 1'b1;

        // odd and even full keep packets, then random lengths
        stall_mode = 1;
        send_packet(3, 4'hf);
        send_packet(4, 4'hf);
        repeat (6)
            send_packet(1 + $urandom % 9, 4'hf);

        // partial tail keep, alone, as upper half, as lone lower half
        send_packet(1, 4'h1);
        send_packet(2, 4'h7);
        send_packet(3, 4'h3);
        send_packet(4, 4'h1);
        wait_drain();

        // long output stall fills the fifo
        saw_full   = 1'b0;
        stall_mode = 2;
        fork
            repeat (6)
                send_packet(7 + $urandom % 3, pick_keep());
            begin
                idle_cycles(60);
                stall_mode = 1;
            end
        join
        if (!saw_full)
        begin
            errors++;
            $display("in_ready never dropped while the output was stalled");
        end
        stall_mode = 0;
        wait_drain();

        // script run, second start mid run ignored, then rerun after done
        pulse_start();
        idle_cycles(30);
        pulse_start();
        wait_runs(1);
        idle_cycles(3);
        pulse_start();
        wait_runs(2);
        idle_cycles(20);
        check_val("script runs", 2, runs_done);

        $display("closing: %0d errors", errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
lp_pkg.sv
word_packer.sv
stream_fifo.sv
word_unpacker.sv
reg_script_rom.sv
gap_timer.sv
reg_script_fsm.sv
loop_platform_top.sv
tb_loop_platform.sv
